// ==== source/div_pkg.sv ====
//--------------------------------------------------------------------------
// shared types and sizes for the iterative divide subsystem
// port count must stay a power of two for the round-robin pointer wrap
//--------------------------------------------------------------------------

package div_pkg;

  // operand and result width
  localparam int div_width = 32;

  // one quotient bit per step
  localparam int div_iters = 32;

  // iteration counter width, holds 0..div_iters
  localparam int count_w = 6;

  // requesting ports in front of the shared divider
  localparam int num_ports = 2;
  localparam int port_w = 1;

  // function select carried in each request
  typedef enum logic [0:0] {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_e;

  // request message, 65 bits
  typedef struct packed {
    div_fn_e               fn;
    logic [div_width-1:0]  a;
    logic [div_width-1:0]  b;
  } div_req_t;

  // response message, remainder in the upper half
  typedef struct packed {
    logic [div_width-1:0]  rem;
    logic [div_width-1:0]  quot;
  } div_resp_t;

endpackage

// ==== source/div_ctrl.sv ====
//--------------------------------------------------------------------------
// divider control: idle/calc/done with a fixed 32-step iteration count
// one request in flight; done holds until the response transfers
//--------------------------------------------------------------------------

module div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e state;
  logic [div_pkg::count_w-1:0] count;

  logic req_go;
  logic resp_go;
  logic last_step;

  // handshake transfers on this edge
  assign req_go = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // counter runs 0..div_iters-1 while in calc
  assign last_step = (count == div_pkg::count_w'(div_pkg::div_iters - 1));

  //------------------------------------------------------------------------
  // state and counter
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          count <= count + 1'b1;
          // leave after the last shift-subtract step
          if (last_step) begin
            state <= st_done;
          end
        end
        st_done: begin
          // result stays put under back-pressure
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  //------------------------------------------------------------------------
  // outputs decoded from state
  //------------------------------------------------------------------------
  always_comb begin
    req_rdy = (state == st_idle);
    resp_val = (state == st_done);
    // idle loads operands only on an actual transfer
    a_en = (state == st_calc) || ((state == st_idle) && req_val);
    b_en = (state == st_idle) && req_val;
    a_mux_sel = (state == st_calc);
  end

  // result shows up one cycle after the last of div_iters steps
  assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> $past(req_val && req_rdy, div_pkg::div_iters + 1));

  // a pending response is not withdrawn before the consumer takes it
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val);

endmodule

// ==== source/div_dpath.sv ====
//--------------------------------------------------------------------------
// restoring divider datapath, one quotient bit per enabled cycle
// divide by zero is not trapped: all-ones quotient, |a| remainder
//--------------------------------------------------------------------------

module div_dpath (
  input  logic              clk,
  input  logic              reset,
  input  div_pkg::div_req_t req_msg,
  input  logic              a_en,
  input  logic              b_en,
  input  logic              a_mux_sel,
  output div_pkg::div_resp_t resp_msg
);

  localparam int w = div_pkg::div_width;

  // sign state captured at load
  logic fn_signed;
  logic a_neg;
  logic b_neg;

  // {remainder, quotient} working register and shifted divisor
  logic [2*w:0] a_reg;
  logic [2*w:0] b_reg;

  logic         req_signed;
  logic [w-1:0] a_mag;
  logic [w-1:0] b_mag;
  logic [2*w:0] a_init;
  logic [2*w:0] a_shift;
  logic [2*w:0] a_diff;
  logic [2*w:0] a_step;
  logic [2*w:0] a_next;
  logic [w-1:0] quot_mag;
  logic [w-1:0] rem_mag;
  logic         quot_neg;
  logic         rem_neg;

  //------------------------------------------------------------------------
  // operand magnitudes from the incoming request
  //------------------------------------------------------------------------
  assign req_signed = (req_msg.fn == div_pkg::div_fn_signed);

  // unsigned operands pass through untouched
  assign a_mag = (req_signed && req_msg.a[w-1]) ? (~req_msg.a + 1'b1) : req_msg.a;
  assign b_mag = (req_signed && req_msg.b[w-1]) ? (~req_msg.b + 1'b1) : req_msg.b;

  // dividend low, divisor lined up with the remainder half
  assign a_init = {{(w+1){1'b0}}, a_mag};

  //------------------------------------------------------------------------
  // one shift-subtract-restore step
  //------------------------------------------------------------------------
  assign a_shift = a_reg << 1;
  assign a_diff = a_shift - b_reg;

  // msb set means the trial subtraction went negative, so restore
  assign a_step = a_diff[2*w] ? a_shift : {a_diff[2*w:1], 1'b1};

  assign a_next = a_mux_sel ? a_step : a_init;

  // sign state has a defined value out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_signed <= 1'b0;
      a_neg <= 1'b0;
      b_neg <= 1'b0;
    end else if (a_en && !a_mux_sel) begin
      fn_signed <= req_signed;
      a_neg <= req_msg.a[w-1];
      b_neg <= req_msg.b[w-1];
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= {1'b0, b_mag, {w{1'b0}}};
    end
  end

  //------------------------------------------------------------------------
  // sign fix at the output
  //------------------------------------------------------------------------
  // after 32 steps the remainder sits in [63:32], quotient in [31:0]
  assign quot_mag = a_reg[w-1:0];
  assign rem_mag = a_reg[2*w-1:w];

  // quotient negative on differing signs, remainder follows a
  assign quot_neg = fn_signed && (a_neg ^ b_neg);
  assign rem_neg = fn_signed && a_neg;

  assign resp_msg.quot = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign resp_msg.rem = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

endmodule

// ==== source/div_arbiter.sv ====
//--------------------------------------------------------------------------
// round-robin arbiter sharing one divider between the request ports
// combinational grant; owner is held until its response transfers
//--------------------------------------------------------------------------

module div_arbiter (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic [div_pkg::num_ports-1:0]                 port_req_val,
  output logic [div_pkg::num_ports-1:0]                 port_req_rdy,
  input  div_pkg::div_req_t [div_pkg::num_ports-1:0]    port_req_msg,
  output logic [div_pkg::num_ports-1:0]                 port_resp_val,
  input  logic [div_pkg::num_ports-1:0]                 port_resp_rdy,
  output div_pkg::div_resp_t [div_pkg::num_ports-1:0]   port_resp_msg,
  output logic                                          div_req_val,
  input  logic                                          div_req_rdy,
  output div_pkg::div_req_t                             div_req_msg,
  input  logic                                          div_resp_val,
  output logic                                          div_resp_rdy,
  input  div_pkg::div_resp_t                            div_resp_msg
);

  localparam int pw = div_pkg::port_w;

  // highest-priority port this round
  logic [pw-1:0] prio;

  // port whose request is inside the divider
  logic [pw-1:0] owner;
  logic          owner_val;

  logic [pw-1:0] grant_idx;
  logic          grant_any;
  logic          req_go;
  logic          resp_go;

  //------------------------------------------------------------------------
  // grant: first valid port at or after the pointer
  //------------------------------------------------------------------------
  always_comb begin
    logic [pw-1:0] idx;
    grant_any = 1'b0;
    grant_idx = prio;
    // scan from the far end so the nearest valid port wins
    for (int k = div_pkg::num_ports - 1; k >= 0; k--) begin
      idx = prio + pw'(k);
      if (port_req_val[idx]) begin
        grant_any = 1'b1;
        grant_idx = idx;
      end
    end
  end

  assign div_req_val = grant_any;
  assign div_req_msg = port_req_msg[grant_idx];

  // only the granted port sees rdy
  always_comb begin
    for (int i = 0; i < div_pkg::num_ports; i++) begin
      port_req_rdy[i] = div_req_rdy && grant_any && (grant_idx == pw'(i));
    end
  end

  assign req_go = div_req_val && div_req_rdy;
  assign resp_go = div_resp_val && div_resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      prio <= '0;
      owner <= '0;
      owner_val <= 1'b0;
    end else begin
      if (req_go) begin
        // pointer moves past the winner
        prio <= grant_idx + 1'b1;
        owner <= grant_idx;
        owner_val <= 1'b1;
      end else if (resp_go) begin
        owner_val <= 1'b0;
      end
    end
  end

  //------------------------------------------------------------------------
  // response steering back to the owner
  //------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < div_pkg::num_ports; i++) begin
      port_resp_val[i] = div_resp_val && owner_val && (owner == pw'(i));
      port_resp_msg[i] = (owner == pw'(i)) ? div_resp_msg : '0;
    end
  end

  // back-pressure comes from the owner alone
  assign div_resp_rdy = owner_val && port_resp_rdy[owner];

  // a divider response always belongs to an accepted request
  assert property (@(posedge clk) disable iff (reset) div_resp_val |-> owner_val);

endmodule

// ==== source/div_subsys.sv ====
//--------------------------------------------------------------------------
// divide subsystem top: arbiter in front of one iterative divider
// per-port val/rdy channels, 33-cycle latency from request to response
//--------------------------------------------------------------------------

module div_subsys (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic [div_pkg::num_ports-1:0]                 req_val,
  output logic [div_pkg::num_ports-1:0]                 req_rdy,
  input  div_pkg::div_req_t [div_pkg::num_ports-1:0]    req_msg,
  output logic [div_pkg::num_ports-1:0]                 resp_val,
  input  logic [div_pkg::num_ports-1:0]                 resp_rdy,
  output div_pkg::div_resp_t [div_pkg::num_ports-1:0]   resp_msg
);

  // shared channel between arbiter and divider
  logic               div_req_val;
  logic               div_req_rdy;
  div_pkg::div_req_t  div_req_msg;
  logic               div_resp_val;
  logic               div_resp_rdy;
  div_pkg::div_resp_t div_resp_msg;

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;

  div_arbiter arb (
    .clk           (clk),
    .reset         (reset),
    .port_req_val  (req_val),
    .port_req_rdy  (req_rdy),
    .port_req_msg  (req_msg),
    .port_resp_val (resp_val),
    .port_resp_rdy (resp_rdy),
    .port_resp_msg (resp_msg),
    .div_req_val   (div_req_val),
    .div_req_rdy   (div_req_rdy),
    .div_req_msg   (div_req_msg),
    .div_resp_val  (div_resp_val),
    .div_resp_rdy  (div_resp_rdy),
    .div_resp_msg  (div_resp_msg)
  );

  div_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (div_req_val),
    .req_rdy   (div_req_rdy),
    .resp_val  (div_resp_val),
    .resp_rdy  (div_resp_rdy),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel)
  );

  div_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .req_msg   (div_req_msg),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel),
    .resp_msg  (div_resp_msg)
  );

endmodule

// ==== tests/tb_div_subsys.sv ====
//--------------------------------------------------------------------------
// testbench for the divide subsystem: two ports, 60 requests each
// expects 33 negedge samples from request transfer to resp_val
//--------------------------------------------------------------------------

module tb_div_subsys;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int w = div_pkg::div_width;
  localparam int np = div_pkg::num_ports;
  localparam int num_reqs = 60;
  localparam int latency = 33;
  // about 120 requests at 40 cycles each, plus margin
  localparam int max_cycles = 20000;

  logic                           clk;
  logic                           reset;
  logic [np-1:0]                  req_val;
  logic [np-1:0]                  req_rdy;
  div_pkg::div_req_t [np-1:0]     req_msg;
  logic [np-1:0]                  resp_val;
  logic [np-1:0]                  resp_rdy;
  div_pkg::div_resp_t [np-1:0]    resp_msg;

  // expected responses and accept cycles, one queue per port
  div_pkg::div_resp_t exp_q [np][$];
  int                 accept_q [np][$];

  div_pkg::div_resp_t hold_msg [np];
  logic [np-1:0]      prev_val;
  logic [np-1:0]      prev_go;
  int                 exp_prio;
  int                 checked;
  int                 cycle;

  div_subsys UUT (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //------------------------------------------------------------------------
  // reference model and helpers
  //------------------------------------------------------------------------
  // divide on magnitudes, then fix the signs
  function automatic div_pkg::div_resp_t div_model(input div_pkg::div_req_t req);
    logic               sgn;
    logic [w-1:0]       am;
    logic [w-1:0]       bm;
    logic [w-1:0]       qm;
    logic [w-1:0]       rm;
    div_pkg::div_resp_t r;
    sgn = (req.fn == div_pkg::div_fn_signed);
    am = (sgn && req.a[w-1]) ? -req.a : req.a;
    bm = (sgn && req.b[w-1]) ? -req.b : req.b;
    // divide by zero: all-ones quotient, remainder is |a|
    if (bm == '0) begin
      qm = '1;
      rm = am;
    end else begin
      qm = am / bm;
      rm = am % bm;
    end
    r.quot = (sgn && (req.a[w-1] ^ req.b[w-1])) ? -qm : qm;
    r.rem = (sgn && req.a[w-1]) ? -rm : rm;
    return r;
  endfunction

  // corner values mixed with random ones
  function automatic logic [w-1:0] pick_operand();
    case ($urandom % 8)
      0: return '0;
      1: return w'(1);
      2: return '1;
      3: return w'(32'h80000000);
      4: return w'($urandom % 16);
      default: return w'($urandom);
    endcase
  endfunction

  task automatic report_error(input string what);
    $display("ERR %0t ns: %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  // one port sends its requests back to back
  task automatic drive_port(input int p);
    div_pkg::div_req_t req;
    for (int n = 0; n < num_reqs; n++) begin
      req.fn = ($urandom % 2 == 0) ? div_pkg::div_fn_unsigned : div_pkg::div_fn_signed;
      req.a = pick_operand();
      req.b = pick_operand();
      req_msg[p] = req;
      req_val[p] = 1'b1;
      // rdy sampled at negedge, transfer on the next rising edge
      do @(negedge clk); while (!req_rdy[p]);
      @(posedge clk);
      #1;
    end
    req_val[p] = 1'b0;
  endtask

  //------------------------------------------------------------------------
  // checkers, sampled at negedge where everything is settled
  //------------------------------------------------------------------------
  always @(negedge clk) begin
    div_pkg::div_resp_t exp;
    if (!reset) begin
      // busy divider must not take a request
      assert (!(|resp_val && |req_rdy)) else report_error("request accepted while result pending");
      assert ($onehot0(req_val & req_rdy)) else report_error("two ports granted at once");
      for (int p = 0; p < np; p++) begin
        if (req_val[p] && req_rdy[p]) begin
          // round robin only matters when both ports compete
          if (&req_val) begin
            assert (p == exp_prio) else report_error($sformatf("grant to port %0d", p));
          end
          exp_prio = (p + 1) % np;
          exp_q[p].push_back(div_model(req_msg[p]));
          accept_q[p].push_back(cycle);
        end
        // pending response never withdrawn
        if (prev_val[p] && !prev_go[p]) begin
          assert (resp_val[p]) else report_error($sformatf("port %0d resp_val dropped", p));
        end
        if (resp_val[p] && !prev_val[p]) begin
          assert (accept_q[p].size() > 0) else report_error("response without a request");
          assert (cycle - accept_q[p][0] == latency)
            else report_error($sformatf("port %0d latency %0d", p, cycle - accept_q[p][0]));
          void'(accept_q[p].pop_front());
          hold_msg[p] = resp_msg[p];
        end else if (resp_val[p]) begin
          assert (resp_msg[p] == hold_msg[p])
            else report_error($sformatf("port %0d response changed under back-pressure", p));
        end
        if (resp_val[p] && resp_rdy[p]) begin
          exp = exp_q[p].pop_front();
          assert (resp_msg[p] == exp)
            else report_error($sformatf("port %0d rem %h quot %h, expected rem %h quot %h",
              p, resp_msg[p].rem, resp_msg[p].quot, exp.rem, exp.quot));
          checked++;
        end
        prev_val[p] = resp_val[p];
        prev_go[p] = resp_val[p] && resp_rdy[p];
      end
    end
  end

  // first responses see rdy held high, then random back-pressure
  initial begin
    wait (reset == 1'b0);
    forever begin
      @(posedge clk);
      #1;
      resp_rdy = (checked < 20) ? '1 : np'($urandom);
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      $display("timeout: not all responses arrived within %0d cycles", max_cycles);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  //------------------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------------------
  initial begin
    void'($urandom(32'h78668dd6));
    reset = 1'b1;
    req_val = '0;
    req_msg = '0;
    resp_rdy = '0;
    prev_val = '0;
    prev_go = '0;
    exp_prio = 0;
    checked = 0;
    cycle = 0;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    assert (resp_val == '0 && UUT.div_req_rdy) else report_error("divider not idle after reset");
    @(posedge clk);
    #1;
    fork
      drive_port(0);
      drive_port(1);
    join
    wait (checked == np * num_reqs);
    repeat (2) @(posedge clk);
    if (exp_q[0].size() == 0 && exp_q[1].size() == 0 && resp_val == '0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("responses left over at the end of the run");
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== tb.f ====
source/div_pkg.sv
source/div_ctrl.sv
source/div_dpath.sv
source/div_arbiter.sv
source/div_subsys.sv
tests/tb_div_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the divide subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_div_subsys -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION PASSED" "$log"; then
  exit 0
else
  echo "pass message not found in $log"
  exit 1
fi
